// ==== verilog/conv_acc_params.svh ====
`ifndef CONV_ACC_PARAMS_SVH
`define CONV_ACC_PARAMS_SVH

// width of one signed accumulator lane
`define CONV_DW 22

// lanes carried side by side in one product vector
`define CONV_DN 6

// partial-sum and bias memory address width, 1024 entries
`define CONV_AW 10

// arithmetic right shift applied to every product
`define CONV_SW 3

`endif

// ==== verilog/conv_data_pkg.sv ====
`include "conv_acc_params.svh"

package conv_data_pkg;

    // one lane, two's complement
    typedef logic signed [`CONV_DW-1:0] lane_t;

    // lane 0 sits in the low bits, 132 bits total
    typedef lane_t [`CONV_DN-1:0] lane_vec_t;

    typedef logic [`CONV_AW-1:0] acc_addr_t;   // memory word address

    typedef logic [`CONV_SW-1:0] shift_t;      // right shift amount

endpackage

// ==== verilog/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

    // bit 1 set means emit a result, bit 0 set means start from bias
    typedef enum logic [1:0] {
        OP_MID   = 2'b00,  // psum + product, write back
        OP_FIRST = 2'b01,  // bias + product, write back
        OP_LAST  = 2'b10,  // psum + product, emit
        OP_ONLY  = 2'b11   // bias + product, emit (single tap job)
    } acc_op_e;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

endpackage

// ==== verilog/tap_sequencer.sv ====
`timescale 1ns/10ps

module tap_sequencer
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        job_start,
    input  acc_addr_t   job_base,
    input  logic [9:0]  job_len,    // vectors per tap minus one
    input  logic [3:0]  job_taps,   // taps minus one
    input  shift_t      job_shift,
    input  logic        prod_valid,
    output logic        prod_ready,
    input  lane_vec_t   prod_data,
    output logic        seq_valid,
    input  logic        seq_ready,
    output lane_vec_t   seq_data,
    output acc_addr_t   seq_addr,
    output acc_op_e     seq_op,
    output shift_t      seq_shift
);

    seq_state_e  state;
    acc_addr_t   base_r;
    logic [9:0]  len_r;
    logic [3:0]  taps_r;
    shift_t      shift_r;
    logic [9:0]  vec_cnt;
    logic [3:0]  tap_cnt;
    acc_op_e     tag_op;
    logic        job_go;
    logic        prod_fire;

    assign job_go     = job_start && (state == SEQ_IDLE);
    assign prod_ready = (state == SEQ_RUN) && (!seq_valid || seq_ready);
    assign prod_fire  = prod_valid && prod_ready;

    always_comb begin
        if (tap_cnt == taps_r)
            tag_op = (tap_cnt == 4'd0) ? OP_ONLY : OP_LAST;
        else
            tag_op = (tap_cnt == 4'd0) ? OP_FIRST : OP_MID;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SEQ_IDLE;
            vec_cnt <= '0;
            tap_cnt <= '0;
        end else if (job_go) begin
            state   <= SEQ_RUN;
            vec_cnt <= '0;
            tap_cnt <= '0;
        end else if (prod_fire) begin
            if (vec_cnt == len_r) begin   // end of tap
                vec_cnt <= '0;
                tap_cnt <= tap_cnt + 4'd1;
                if (tap_cnt == taps_r)
                    state <= SEQ_IDLE;
            end else begin
                vec_cnt <= vec_cnt + 10'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_go) begin
            base_r  <= job_base;
            len_r   <= job_len;
            taps_r  <= job_taps;
            shift_r <= job_shift;
        end
    end

    // output stage, held until the buffer takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            seq_valid <= 1'b0;
        else if (prod_fire)
            seq_valid <= 1'b1;
        else if (seq_ready)
            seq_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (prod_fire) begin
            seq_data  <= prod_data;
            seq_addr  <= base_r + vec_cnt;
            seq_op    <= tag_op;
            seq_shift <= shift_r;
        end
    end

endmodule

// ==== verilog/acc_skid_buffer.sv ====
`timescale 1ns/10ps

module acc_skid_buffer
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  lane_vec_t  in_data,
    input  acc_addr_t  in_addr,
    input  acc_op_e    in_op,
    input  shift_t     in_shift,
    output logic       out_valid,
    input  logic       out_ready,
    output lane_vec_t  out_data,
    output acc_addr_t  out_addr,
    output acc_op_e    out_op,
    output shift_t     out_shift
);

    logic       skid_valid;
    lane_vec_t  skid_data;
    acc_addr_t  skid_addr;
    acc_op_e    skid_op;
    shift_t     skid_shift;
    logic       in_fire;
    logic       main_load;

    assign in_fire   = in_valid && in_ready;
    assign main_load = !out_valid || out_ready;   // main register free next edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (main_load) begin
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (in_fire) begin   // output stalled, park in skid
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            out_data  <= skid_valid ? skid_data  : in_data;
            out_addr  <= skid_valid ? skid_addr  : in_addr;
            out_op    <= skid_valid ? skid_op    : in_op;
            out_shift <= skid_valid ? skid_shift : in_shift;
        end
        if (in_ready) begin   // skid empty, safe to overwrite
            skid_data  <= in_data;
            skid_addr  <= in_addr;
            skid_op    <= in_op;
            skid_shift <= in_shift;
        end
    end

endmodule

// ==== verilog/conv_acc.sv ====
`timescale 1ns/10ps
`include "conv_acc_params.svh"

module conv_acc
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       buf_valid,
    output logic       buf_ready,
    input  lane_vec_t  buf_data,
    input  acc_addr_t  buf_addr,
    input  acc_op_e    buf_op,
    input  shift_t     buf_shift,
    output acc_addr_t  rd_addr,        // shared by bias and psum memories
    input  lane_vec_t  bias_rd_data,
    input  lane_vec_t  psum_rd_data,
    output logic       psum_wr_en,
    output acc_addr_t  psum_wr_addr,
    output lane_vec_t  psum_wr_data,
    output logic       res_valid,
    output acc_addr_t  res_addr,
    output lane_vec_t  res_data
);

    logic       acc_fire;
    lane_vec_t  prod_sft;

    // stage 1, aligned with the memory read
    logic       s1_valid;
    acc_op_e    s1_op;
    acc_addr_t  s1_addr;
    lane_vec_t  s1_prod;
    logic       s1_use_bias;

    // stage 2
    lane_vec_t  operand;
    lane_vec_t  sum;
    logic       s1_emit;
    lane_vec_t  sum_r;
    acc_addr_t  addr_r;

    assign buf_ready = 1'b1;               // never stalls
    assign acc_fire  = buf_valid && buf_ready;
    assign rd_addr   = buf_addr;           // read issued in the accept cycle

    always_comb begin
        for (int i = 0; i < `CONV_DN; i++) begin
            prod_sft[i] = $signed(buf_data[i]) >>> buf_shift;   // sign kept
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= acc_fire;
    end

    always_ff @(posedge clk) begin
        if (acc_fire) begin
            s1_op       <= buf_op;
            s1_addr     <= buf_addr;
            s1_prod     <= prod_sft;
            s1_use_bias <= (buf_op == OP_FIRST) || (buf_op == OP_ONLY);
        end
    end

    // first tap starts from bias, later taps from the stored partial sum
    assign operand = s1_use_bias ? bias_rd_data : psum_rd_data;
    assign s1_emit = (s1_op == OP_LAST) || (s1_op == OP_ONLY);

    always_comb begin
        for (int i = 0; i < `CONV_DN; i++) begin
            sum[i] = s1_prod[i] + operand[i];   // wraps in lane width
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_wr_en <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            psum_wr_en <= s1_valid && !s1_emit;
            res_valid  <= s1_valid && s1_emit;
        end
    end

    always_ff @(posedge clk) begin
        sum_r  <= sum;
        addr_r <= s1_addr;
    end

    // one register feeds both the write-back and the result port
    assign psum_wr_addr = addr_r;
    assign psum_wr_data = sum_r;
    assign res_addr     = addr_r;
    assign res_data     = sum_r;

endmodule

// ==== verilog/acc_ram.sv ====
`timescale 1ns/10ps
`include "conv_acc_params.svh"

module acc_ram
    import conv_data_pkg::*;
(
    input  logic       clk,
    input  logic       wr_en,
    input  acc_addr_t  wr_addr,
    input  lane_vec_t  wr_data,
    input  acc_addr_t  rd_addr,
    output lane_vec_t  rd_data
);

    lane_vec_t mem [0:(1 << `CONV_AW)-1];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read, old data on a same-cycle collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/conv_acc_top.sv ====
`timescale 1ns/10ps

module conv_acc_top
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        job_start,
    input  acc_addr_t   job_base,
    input  logic [9:0]  job_len,
    input  logic [3:0]  job_taps,
    input  shift_t      job_shift,
    input  logic        prod_valid,
    output logic        prod_ready,
    input  lane_vec_t   prod_data,
    input  logic        bias_wr_en,
    input  acc_addr_t   bias_wr_addr,
    input  lane_vec_t   bias_wr_data,
    output logic        res_valid,
    output acc_addr_t   res_addr,
    output lane_vec_t   res_data
);

    logic       seq_valid;
    logic       seq_ready;
    lane_vec_t  seq_data;
    acc_addr_t  seq_addr;
    acc_op_e    seq_op;
    shift_t     seq_shift;

    logic       buf_valid;
    logic       buf_ready;
    lane_vec_t  buf_data;
    acc_addr_t  buf_addr;
    acc_op_e    buf_op;
    shift_t     buf_shift;

    acc_addr_t  rd_addr;
    lane_vec_t  bias_rd_data;
    lane_vec_t  psum_rd_data;
    logic       psum_wr_en;
    acc_addr_t  psum_wr_addr;
    lane_vec_t  psum_wr_data;

    tap_sequencer tap_sequencer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .job_start  (job_start),
        .job_base   (job_base),
        .job_len    (job_len),
        .job_taps   (job_taps),
        .job_shift  (job_shift),
        .prod_valid (prod_valid),
        .prod_ready (prod_ready),
        .prod_data  (prod_data),
        .seq_valid  (seq_valid),
        .seq_ready  (seq_ready),
        .seq_data   (seq_data),
        .seq_addr   (seq_addr),
        .seq_op     (seq_op),
        .seq_shift  (seq_shift)
    );

    acc_skid_buffer acc_skid_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (seq_valid),
        .in_ready  (seq_ready),
        .in_data   (seq_data),
        .in_addr   (seq_addr),
        .in_op     (seq_op),
        .in_shift  (seq_shift),
        .out_valid (buf_valid),
        .out_ready (buf_ready),
        .out_data  (buf_data),
        .out_addr  (buf_addr),
        .out_op    (buf_op),
        .out_shift (buf_shift)
    );

    conv_acc conv_acc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .buf_valid    (buf_valid),
        .buf_ready    (buf_ready),
        .buf_data     (buf_data),
        .buf_addr     (buf_addr),
        .buf_op       (buf_op),
        .buf_shift    (buf_shift),
        .rd_addr      (rd_addr),
        .bias_rd_data (bias_rd_data),
        .psum_rd_data (psum_rd_data),
        .psum_wr_en   (psum_wr_en),
        .psum_wr_addr (psum_wr_addr),
        .psum_wr_data (psum_wr_data),
        .res_valid    (res_valid),
        .res_addr     (res_addr),
        .res_data     (res_data)
    );

    // bias is loaded from outside, partial sums by the accumulator
    acc_ram bias_ram (
        .clk     (clk),
        .wr_en   (bias_wr_en),
        .wr_addr (bias_wr_addr),
        .wr_data (bias_wr_data),
        .rd_addr (rd_addr),
        .rd_data (bias_rd_data)
    );

    acc_ram psum_ram (
        .clk     (clk),
        .wr_en   (psum_wr_en),
        .wr_addr (psum_wr_addr),
        .wr_data (psum_wr_data),
        .rd_addr (rd_addr),
        .rd_data (psum_rd_data)
    );

endmodule

// ==== tests/conv_acc_tb.sv ====
`timescale 1ns/10ps
`include "conv_acc_params.svh"

module conv_acc_tb
    import conv_data_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int ITEM_COUNT = 8 + 72 + 18 + 64 + 35;   // product transfers over all tests
    localparam int BIAS_COUNT = 8 + 8 + 6 + 8 + 15;
    // worst case 4 cycles per product with gaps plus start and drain per job
    localparam int WATCHDOG_CYCLES = (4 * ITEM_COUNT + BIAS_COUNT + 5 * 20) * 2;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        job_start;
    acc_addr_t   job_base;
    logic [9:0]  job_len;
    logic [3:0]  job_taps;
    shift_t      job_shift;
    logic        prod_valid;
    logic        prod_ready;
    lane_vec_t   prod_data;
    logic        bias_wr_en;
    acc_addr_t   bias_wr_addr;
    lane_vec_t   bias_wr_data;
    logic        res_valid;
    acc_addr_t   res_addr;
    lane_vec_t   res_data;

    logic [31:0] lfsr = 32'hea577ef1;
    lane_vec_t   prod_buf [0:15][0:31];   // [tap][vector]
    lane_vec_t   bias_model [0:(1 << `CONV_AW)-1];
    acc_addr_t   exp_addr_q[$];
    lane_vec_t   exp_data_q[$];
    logic        job_active = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    conv_acc_top conv_acc_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_start    (job_start),
        .job_base     (job_base),
        .job_len      (job_len),
        .job_taps     (job_taps),
        .job_shift    (job_shift),
        .prod_valid   (prod_valid),
        .prod_ready   (prod_ready),
        .prod_data    (prod_data),
        .bias_wr_en   (bias_wr_en),
        .bias_wr_addr (bias_wr_addr),
        .bias_wr_data (bias_wr_data),
        .res_valid    (res_valid),
        .res_addr     (res_addr),
        .res_data     (res_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic lane_vec_t rand_vec(input logic neg);
        lane_vec_t v;
        for (int l = 0; l < `CONV_DN; l++) begin
            v[l] = `CONV_DW'(rand_bits(`CONV_DW));
            if (neg)
                v[l][`CONV_DW-1] = 1'b1;   // force a negative lane
        end
        return v;
    endfunction

    // bias plus every tap's product shifted right with sign and wrapped per lane
    function automatic lane_vec_t model_sum(input acc_addr_t addr, input int v,
                                            input int ntaps, input shift_t sh);
        lane_vec_t acc;
        lane_t     a;
        lane_t     p;
        acc = bias_model[addr];
        for (int l = 0; l < `CONV_DN; l++) begin
            a = acc[l];
            for (int t = 0; t < ntaps; t++) begin
                p = prod_buf[t][v][l];
                a = a + (p >>> sh);
            end
            acc[l] = a;
        end
        return acc;
    endfunction

    task automatic fill_products(input int ntaps, input int nvec, input logic neg);
        for (int t = 0; t < ntaps; t++)
            for (int v = 0; v < nvec; v++)
                prod_buf[t][v] = rand_vec(neg);
    endtask

    task automatic load_bias(input acc_addr_t base, input int n);
        for (int v = 0; v < n; v++) begin
            @(negedge clk);
            bias_wr_en   = 1'b1;
            bias_wr_addr = acc_addr_t'(base + v);
            bias_wr_data = rand_vec(1'b0);
            bias_model[bias_wr_addr] = bias_wr_data;
        end
        @(negedge clk);
        bias_wr_en = 1'b0;
    endtask

    // expected result is queued only once its last-tap product has transferred
    task automatic run_job(input acc_addr_t base, input int nvec, input int ntaps,
                           input shift_t sh, input logic gaps);
        int idle;
        @(negedge clk);
        job_base   = base;
        job_len    = 10'(nvec - 1);
        job_taps   = 4'(ntaps - 1);
        job_shift  = sh;
        job_start  = 1'b1;
        job_active = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        for (int t = 0; t < ntaps; t++) begin
            for (int v = 0; v < nvec; v++) begin
                idle = gaps ? int'(rand_bits(2)) : 0;
                repeat (idle) @(negedge clk);
                prod_valid = 1'b1;
                prod_data  = prod_buf[t][v];
                while (!prod_ready)
                    @(negedge clk);
                @(posedge clk);   // transfer on this edge
                if (t == ntaps - 1) begin
                    exp_addr_q.push_back(acc_addr_t'(base + v));
                    exp_data_q.push_back(model_sum(acc_addr_t'(base + v), v, ntaps, sh));
                    if (v == nvec - 1)
                        job_active = 1'b0;
                end
                @(negedge clk);
                prod_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_addr_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);   // room for a stray extra result
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d (%s) finished, %0d checks, %0d errors so far",
                 tests, name, checks, errors);
    endtask

    // outputs sampled mid-cycle away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (job_active || !prod_ready) else begin
                errors++;
                $display("prod_ready was high at %0t while no job was running", $time);
            end
            if (res_valid) begin
                checks++;
                assert (exp_addr_q.size() != 0) else begin
                    errors++;
                    $display("a result came out at %0t with none expected", $time);
                end
                if (exp_addr_q.size() != 0) begin
                    assert (res_addr == exp_addr_q[0] && res_data == exp_data_q[0]) else begin
                        errors++;
                        $display("CHECK FAILED at %0t: addr %h data %h, expected addr %h data %h",
                                 $time, res_addr, res_data, exp_addr_q[0], exp_data_q[0]);
                    end
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        job_start    = 1'b0;
        job_base     = '0;
        job_len      = '0;
        job_taps     = '0;
        job_shift    = '0;
        prod_valid   = 1'b0;
        prod_data    = '0;
        bias_wr_en   = 1'b0;
        bias_wr_addr = '0;
        bias_wr_data = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        load_bias(10'h010, 8);
        fill_products(1, 8, 1'b0);
        run_job(10'h010, 8, 1, 3'd0, 1'b0);
        wait_drain();
        report_test("single tap, shift 0");

        load_bias(10'h080, 8);
        fill_products(9, 8, 1'b0);
        run_job(10'h080, 8, 9, 3'd0, 1'b0);
        wait_drain();
        report_test("9 taps, 8 vectors");

        load_bias(10'h120, 6);
        fill_products(3, 6, 1'b1);
        run_job(10'h120, 6, 3, 3'd5, 1'b0);
        wait_drain();
        report_test("shift 5, negative products");

        load_bias(10'h200, 8);
        fill_products(4, 8, 1'b0);
        run_job(10'h200, 8, 4, 3'd2, 1'b0);
        wait_drain();
        run_job(10'h200, 8, 4, 3'd2, 1'b1);   // same job again with valid gaps
        wait_drain();
        report_test("random valid gaps");

        load_bias(10'h040, 10);
        load_bias(10'h3f8, 5);
        fill_products(3, 10, 1'b0);
        run_job(10'h040, 10, 2, 3'd1, 1'b1);
        run_job(10'h3f8, 5, 3, 3'd3, 1'b0);   // starts right after the last transfer
        wait_drain();
        report_test("back-to-back jobs");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/conv_data_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/tap_sequencer.sv
verilog/acc_skid_buffer.sv
verilog/conv_acc.sv
verilog/acc_ram.sv
verilog/conv_acc_top.sv
tests/conv_acc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps -f sources.f \
        --top-module conv_acc_tb -o conv_acc_sim \
    && ./obj_dir/conv_acc_sim | tee /dev/stderr | grep -q "^Result: PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
